/* hw/tinyrv1_pkg.sv */
`default_nettype none

package tinyrv1_pkg;

  // ==============================
  // Widths
  // ==============================

  typedef logic [31:0] word_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [11:0] csr_num_t;
  typedef logic [1:0]  csr_idx_t;
  typedef logic [1:0]  byp_sel_t;

  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

  typedef logic [QUEUE_PTR_W-1:0] qptr_t;
  typedef logic [QUEUE_CNT_W-1:0] qcnt_t;

  // Word addressed, byte address bits 7:2
  localparam int DMEM_WORDS  = 64;
  localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

  typedef logic [DMEM_ADDR_W-1:0] dmem_addr_t;

  // Bypass sources into D
  localparam byp_sel_t BYP_NONE = 2'd0;
  localparam byp_sel_t BYP_X    = 2'd1;
  localparam byp_sel_t BYP_M    = 2'd2;
  localparam byp_sel_t BYP_W    = 2'd3;

  // ==============================
  // Encodings
  // ==============================

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [6:0] F7_MUL   = 7'b0000001;
  localparam logic [2:0] F3_CSRRW = 3'b001;

  // Output CSRs
  localparam csr_num_t CSR_OUT0 = 12'h7c2;
  localparam csr_num_t CSR_OUT1 = 12'h7c3;
  localparam csr_num_t CSR_OUT2 = 12'h7c4;

  // ==============================
  // Control bundles
  // ==============================

  typedef struct packed {
    byp_sel_t op1_byp;
    byp_sel_t op2_byp;
    logic     imm_s;
    logic     op2_imm;
    logic     csrw_en;
    csr_idx_t csr_idx;
  } ctrl_d_t;

  typedef struct packed {
    logic is_mul;
  } ctrl_x_t;

  typedef struct packed {
    logic mem_val;
    logic mem_store;
    logic wb_mem;
  } ctrl_m_t;

  typedef struct packed {
    logic      rf_wen;
    reg_addr_t rf_waddr;
  } ctrl_w_t;

  typedef struct packed {
    ctrl_d_t d;
    ctrl_x_t x;
    ctrl_m_t m;
    ctrl_w_t w;
    logic    reg_en_d;
  } ctrl_bundle_t;

  typedef struct packed {
    csr_idx_t idx;
    word_t    data;
  } csr_out_t;

endpackage

`default_nettype wire

/* hw/proc_inst_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module proc_inst_queue (
  input  wire                 clk,
  input  wire                 arst_n,
  input  wire                 in_val,
  output logic                in_rdy,
  input  wire tinyrv1_pkg::inst_t in_data,
  output logic                head_val,
  output tinyrv1_pkg::inst_t  head,
  input  wire                 head_pop
);

  tinyrv1_pkg::inst_t mem [tinyrv1_pkg::QUEUE_DEPTH];

  tinyrv1_pkg::qptr_t wr_ptr;
  tinyrv1_pkg::qptr_t rd_ptr;
  tinyrv1_pkg::qcnt_t count;

  logic push;
  logic pop;

  // Wraps at the last entry, depth need not be a power of two
  function automatic tinyrv1_pkg::qptr_t ptr_inc(input tinyrv1_pkg::qptr_t p);
    if (p == tinyrv1_pkg::qptr_t'(tinyrv1_pkg::QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign in_rdy   = (count < tinyrv1_pkg::qcnt_t'(tinyrv1_pkg::QUEUE_DEPTH));
  assign head_val = (count != '0);
  assign head     = mem[rd_ptr];

  assign push = in_val & in_rdy;
  assign pop  = head_pop & head_val;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/proc_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module proc_ctrl (
  input  wire                      clk,
  input  wire                      arst_n,
  input  wire tinyrv1_pkg::inst_t  inst_D,
  input  wire                      inst_val_D,
  output logic                     inst_pop,
  output tinyrv1_pkg::ctrl_bundle_t ctrl
);

  tinyrv1_pkg::inst_t inst_X;
  tinyrv1_pkg::inst_t inst_M;
  tinyrv1_pkg::inst_t inst_W;

  logic val_X;
  logic val_M;
  logic val_W;

  tinyrv1_pkg::reg_addr_t rs1_D;
  tinyrv1_pkg::reg_addr_t rs2_D;
  tinyrv1_pkg::reg_addr_t rd_X;
  tinyrv1_pkg::reg_addr_t rd_M;
  tinyrv1_pkg::reg_addr_t rd_W;
  tinyrv1_pkg::csr_num_t  csr_num_D;
  tinyrv1_pkg::csr_idx_t  csr_idx_D;

  logic rs1_en_D;
  logic rs2_en_D;
  logic csrw_D;
  logic mapped_D;
  logic lw_X;
  logic fwd_X;
  logic fwd_M;
  logic fwd_W;
  logic stall_D;
  logic go_D;

  function automatic logic writes_rd(input tinyrv1_pkg::inst_t i);
    return (i[6:0] == tinyrv1_pkg::OPC_OP) || (i[6:0] == tinyrv1_pkg::OPC_OP_IMM) ||
           (i[6:0] == tinyrv1_pkg::OPC_LOAD);
  endfunction

  function automatic tinyrv1_pkg::byp_sel_t byp_prio(input logic hit_x, input logic hit_m,
                                                     input logic hit_w);
    if (hit_x) return tinyrv1_pkg::BYP_X;
    if (hit_m) return tinyrv1_pkg::BYP_M;
    if (hit_w) return tinyrv1_pkg::BYP_W;
    return tinyrv1_pkg::BYP_NONE;
  endfunction

  // ==============================
  // Stage validity and inst regs
  // ==============================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      val_X <= 1'b0;
      val_M <= 1'b0;
      val_W <= 1'b0;
    end else begin
      val_X <= go_D;
      val_M <= val_X;
      val_W <= val_M;
    end
  end

  always_ff @(posedge clk) begin
    inst_X <= inst_D;
    inst_M <= inst_X;
    inst_W <= inst_M;
  end

  // ==============================
  // Hazards
  // ==============================

  assign rs1_D     = inst_D[19:15];
  assign rs2_D     = inst_D[24:20];
  assign rd_X      = inst_X[11:7];
  assign rd_M      = inst_M[11:7];
  assign rd_W      = inst_W[11:7];
  assign csr_num_D = inst_D[31:20];

  assign csrw_D   = (inst_D[6:0] == tinyrv1_pkg::OPC_SYSTEM) &&
                    (inst_D[14:12] == tinyrv1_pkg::F3_CSRRW);
  assign rs1_en_D = writes_rd(inst_D) || csrw_D || (inst_D[6:0] == tinyrv1_pkg::OPC_STORE);
  assign rs2_en_D = (inst_D[6:0] == tinyrv1_pkg::OPC_OP) ||
                    (inst_D[6:0] == tinyrv1_pkg::OPC_STORE);

  // Writers able to forward, x0 never forwards
  assign lw_X  = val_X && (inst_X[6:0] == tinyrv1_pkg::OPC_LOAD) && (rd_X != '0);
  assign fwd_X = val_X && writes_rd(inst_X) && (rd_X != '0) && !lw_X;
  assign fwd_M = val_M && writes_rd(inst_M) && (rd_M != '0);
  assign fwd_W = val_W && writes_rd(inst_W) && (rd_W != '0);

  // Load data is not ready until M
  assign stall_D = inst_val_D && lw_X &&
                   ((rs1_en_D && (rs1_D == rd_X)) || (rs2_en_D && (rs2_D == rd_X)));
  assign go_D     = inst_val_D && !stall_D;
  assign inst_pop = go_D;

  always_comb begin
    mapped_D = 1'b1;
    case (csr_num_D)
      tinyrv1_pkg::CSR_OUT0: csr_idx_D = 2'd0;
      tinyrv1_pkg::CSR_OUT1: csr_idx_D = 2'd1;
      tinyrv1_pkg::CSR_OUT2: csr_idx_D = 2'd2;
      default: begin
        csr_idx_D = 2'd0;
        mapped_D  = 1'b0;
      end
    endcase
  end

  // ==============================
  // Control decode per stage
  // ==============================

  always_comb begin
    ctrl = '0;
    ctrl.reg_en_d = go_D;

    ctrl.d.op1_byp = byp_prio(inst_val_D && rs1_en_D && fwd_X && (rs1_D == rd_X),
                              inst_val_D && rs1_en_D && fwd_M && (rs1_D == rd_M),
                              inst_val_D && rs1_en_D && fwd_W && (rs1_D == rd_W));
    ctrl.d.op2_byp = byp_prio(inst_val_D && rs2_en_D && fwd_X && (rs2_D == rd_X),
                              inst_val_D && rs2_en_D && fwd_M && (rs2_D == rd_M),
                              inst_val_D && rs2_en_D && fwd_W && (rs2_D == rd_W));
    ctrl.d.imm_s   = (inst_D[6:0] == tinyrv1_pkg::OPC_STORE);
    ctrl.d.op2_imm = (inst_D[6:0] == tinyrv1_pkg::OPC_OP_IMM) ||
                     (inst_D[6:0] == tinyrv1_pkg::OPC_LOAD) || ctrl.d.imm_s;
    ctrl.d.csrw_en = go_D && csrw_D && mapped_D;
    ctrl.d.csr_idx = csr_idx_D;

    ctrl.x.is_mul = val_X && (inst_X[6:0] == tinyrv1_pkg::OPC_OP) &&
                    (inst_X[31:25] == tinyrv1_pkg::F7_MUL);

    ctrl.m.wb_mem    = val_M && (inst_M[6:0] == tinyrv1_pkg::OPC_LOAD);
    ctrl.m.mem_store = val_M && (inst_M[6:0] == tinyrv1_pkg::OPC_STORE);
    ctrl.m.mem_val   = ctrl.m.wb_mem || ctrl.m.mem_store;

    ctrl.w.rf_wen   = val_W && writes_rd(inst_W);
    ctrl.w.rf_waddr = rd_W;
  end

endmodule

`default_nettype wire

/* hw/proc_dpath.sv */
`timescale 1ns/100ps
`default_nettype none

module proc_dpath (
  input  wire                            clk,
  input  wire                            arst_n,
  input  wire tinyrv1_pkg::inst_t        inst_D,
  input  wire tinyrv1_pkg::ctrl_bundle_t ctrl,
  output logic                           csr_out_val,
  output tinyrv1_pkg::csr_out_t          csr_out
);

  tinyrv1_pkg::word_t rf   [32];
  tinyrv1_pkg::word_t dmem [tinyrv1_pkg::DMEM_WORDS];

  tinyrv1_pkg::reg_addr_t rs1_D;
  tinyrv1_pkg::reg_addr_t rs2_D;
  tinyrv1_pkg::word_t     rf_rs1_D;
  tinyrv1_pkg::word_t     rf_rs2_D;
  tinyrv1_pkg::word_t     imm_D;
  tinyrv1_pkg::word_t     op1_D;
  tinyrv1_pkg::word_t     rs2_val_D;
  tinyrv1_pkg::word_t     op2_D;

  tinyrv1_pkg::word_t op1_X;
  tinyrv1_pkg::word_t op2_X;
  tinyrv1_pkg::word_t sd_X;
  tinyrv1_pkg::word_t result_X;

  tinyrv1_pkg::word_t     result_M;
  tinyrv1_pkg::word_t     sd_M;
  tinyrv1_pkg::dmem_addr_t addr_M;
  tinyrv1_pkg::word_t     wb_M;

  tinyrv1_pkg::word_t wb_W;

  function automatic tinyrv1_pkg::word_t byp_mux(input tinyrv1_pkg::byp_sel_t sel,
                                                 input tinyrv1_pkg::word_t rf_v,
                                                 input tinyrv1_pkg::word_t x_v,
                                                 input tinyrv1_pkg::word_t m_v,
                                                 input tinyrv1_pkg::word_t w_v);
    case (sel)
      tinyrv1_pkg::BYP_X: return x_v;
      tinyrv1_pkg::BYP_M: return m_v;
      tinyrv1_pkg::BYP_W: return w_v;
      default:            return rf_v;
    endcase
  endfunction

  // ==============================
  // Stage D
  // ==============================

  assign rs1_D    = inst_D[19:15];
  assign rs2_D    = inst_D[24:20];
  assign rf_rs1_D = (rs1_D == '0) ? '0 : rf[rs1_D];
  assign rf_rs2_D = (rs2_D == '0) ? '0 : rf[rs2_D];

  // I-type or S-type, sign extended
  assign imm_D = ctrl.d.imm_s ? {{20{inst_D[31]}}, inst_D[31:25], inst_D[11:7]}
                              : {{20{inst_D[31]}}, inst_D[31:20]};

  assign op1_D     = byp_mux(ctrl.d.op1_byp, rf_rs1_D, result_X, wb_M, wb_W);
  assign rs2_val_D = byp_mux(ctrl.d.op2_byp, rf_rs2_D, result_X, wb_M, wb_W);
  assign op2_D     = ctrl.d.op2_imm ? imm_D : rs2_val_D;

  always_ff @(posedge clk) begin
    if (ctrl.reg_en_d) begin
      op1_X <= op1_D;
      op2_X <= op2_D;
      sd_X  <= rs2_val_D;
    end
  end

  // ==============================
  // Stage X and M
  // ==============================

  // Low half of the product only
  assign result_X = ctrl.x.is_mul ? op1_X * op2_X : op1_X + op2_X;

  always_ff @(posedge clk) begin
    result_M <= result_X;
    sd_M     <= sd_X;
    wb_W     <= wb_M;
  end

  assign addr_M = result_M[tinyrv1_pkg::DMEM_ADDR_W+1:2];
  assign wb_M   = ctrl.m.wb_mem ? dmem[addr_M] : result_M;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < tinyrv1_pkg::DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (ctrl.m.mem_val && ctrl.m.mem_store) begin
      dmem[addr_M] <= sd_M;
    end
  end

  // ==============================
  // Stage W and CSR output
  // ==============================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        rf[i] <= '0;
      end
    end else if (ctrl.w.rf_wen && (ctrl.w.rf_waddr != '0)) begin
      rf[ctrl.w.rf_waddr] <= wb_W;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      csr_out_val <= 1'b0;
    end else begin
      csr_out_val <= ctrl.d.csrw_en;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.d.csrw_en) begin
      csr_out.idx  <= ctrl.d.csr_idx;
      csr_out.data <= op1_D;
    end
  end

endmodule

`default_nettype wire

/* hw/proc_top.sv */
`timescale 1ns/100ps
`default_nettype none

module proc_top (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire                     inst_val,
  output logic                    inst_rdy,
  input  wire tinyrv1_pkg::inst_t inst,
  output logic                    csr_out_val,
  output tinyrv1_pkg::csr_out_t   csr_out
);

  logic                      head_val;
  logic                      head_pop;
  tinyrv1_pkg::inst_t        head;
  tinyrv1_pkg::ctrl_bundle_t ctrl;

  proc_inst_queue u_queue (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_val   (inst_val),
    .in_rdy   (inst_rdy),
    .in_data  (inst),
    .head_val (head_val),
    .head     (head),
    .head_pop (head_pop)
  );

  // Queue head is the D-stage instruction
  proc_ctrl u_ctrl (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst_D     (head),
    .inst_val_D (head_val),
    .inst_pop   (head_pop),
    .ctrl       (ctrl)
  );

  proc_dpath u_dpath (
    .clk         (clk),
    .arst_n      (arst_n),
    .inst_D      (head),
    .ctrl        (ctrl),
    .csr_out_val (csr_out_val),
    .csr_out     (csr_out)
  );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  // 40 ns period
  initial begin
    clk = 1'b0;
  end

  always #20 clk = ~clk;

endmodule

`default_nettype wire

/* testbench/proc_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module proc_tb;

  localparam int N_INST          = 200;
  localparam int RST_CYCLES      = 10;
  localparam int DRAIN_CYCLES    = 40;
  localparam int WATCHDOG_CYCLES = 10 * N_INST + RST_CYCLES;
  localparam int BURST_START     = 100;
  localparam int BURST_LEN       = 16;

  logic                  clk;
  logic                  arst_n;
  logic                  inst_val;
  logic                  inst_rdy;
  tinyrv1_pkg::inst_t    inst;
  logic                  csr_out_val;
  tinyrv1_pkg::csr_out_t csr_out;

  tinyrv1_pkg::inst_t    prog [N_INST];
  tinyrv1_pkg::word_t    mreg [32];
  tinyrv1_pkg::word_t    mmem [tinyrv1_pkg::DMEM_WORDS];
  tinyrv1_pkg::csr_out_t exp_q [$];

  logic [31:0] rng_state;
  int          prog_mapped;
  int          strobes;
  int          rdy_low_cycles;
  int          mismatch_errors;
  int          other_errors;

  tb_clock_gen u_clk (
    .clk (clk)
  );

  proc_top UUT (
    .clk         (clk),
    .arst_n      (arst_n),
    .inst_val    (inst_val),
    .inst_rdy    (inst_rdy),
    .inst        (inst),
    .csr_out_val (csr_out_val),
    .csr_out     (csr_out)
  );

  // ==============================
  // Random numbers and encoders
  // ==============================

  function automatic int random_below(input int n);
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return int'({8'd0, rng_state[31:8]} % 32'(n));
  endfunction

  function automatic tinyrv1_pkg::reg_addr_t random_reg();
    return tinyrv1_pkg::reg_addr_t'(random_below(8));
  endfunction

  function automatic logic in_burst(input int i);
    return (i >= BURST_START) && (i < BURST_START + BURST_LEN);
  endfunction

  function automatic tinyrv1_pkg::csr_num_t csr_of_pick(input int pick);
    case (pick)
      0:       return tinyrv1_pkg::CSR_OUT0;
      1:       return tinyrv1_pkg::CSR_OUT1;
      2:       return tinyrv1_pkg::CSR_OUT2;
      default: return 12'h7c0;
    endcase
  endfunction

  function automatic tinyrv1_pkg::inst_t enc_r(input logic [6:0] f7,
                                               input tinyrv1_pkg::reg_addr_t rs2,
                                               input tinyrv1_pkg::reg_addr_t rs1,
                                               input tinyrv1_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, 3'b000, rd, tinyrv1_pkg::OPC_OP};
  endfunction

  function automatic tinyrv1_pkg::inst_t enc_i(input logic [11:0] imm,
                                               input tinyrv1_pkg::reg_addr_t rs1,
                                               input logic [2:0] f3,
                                               input tinyrv1_pkg::reg_addr_t rd,
                                               input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic tinyrv1_pkg::inst_t enc_s(input logic [11:0] imm,
                                               input tinyrv1_pkg::reg_addr_t rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], tinyrv1_pkg::OPC_STORE};
  endfunction

  function automatic tinyrv1_pkg::inst_t enc_csrw(input tinyrv1_pkg::csr_num_t csr,
                                                  input tinyrv1_pkg::reg_addr_t rs1);
    return {csr, rs1, tinyrv1_pkg::F3_CSRRW, 5'd0, tinyrv1_pkg::OPC_SYSTEM};
  endfunction

  // Mix weighted toward CSRW so most results get observed
  task automatic build_program();
    int                     kind;
    int                     pick;
    tinyrv1_pkg::reg_addr_t burst_rd;
    burst_rd = '0;
    for (int i = 0; i < N_INST; i++) begin
      kind = random_below(16);
      if (in_burst(i) && (((i - BURST_START) % 2) == 0)) begin
        // Loads used at once stall D and back up the queue
        burst_rd = tinyrv1_pkg::reg_addr_t'(1 + random_below(7));
        prog[i]  = enc_i(12'(random_below(64) * 4), 5'd0, 3'b010, burst_rd,
                         tinyrv1_pkg::OPC_LOAD);
      end else if (in_burst(i)) begin
        prog_mapped++;
        prog[i] = enc_csrw(csr_of_pick(random_below(3)), burst_rd);
      end else if (kind < 3) begin
        prog[i] = enc_r(7'd0, random_reg(), random_reg(), random_reg());
      end else if (kind < 5) begin
        prog[i] = enc_i(12'(random_below(4096)), random_reg(), 3'b000, random_reg(),
                        tinyrv1_pkg::OPC_OP_IMM);
      end else if (kind < 7) begin
        prog[i] = enc_r(tinyrv1_pkg::F7_MUL, random_reg(), random_reg(), random_reg());
      end else if (kind < 9) begin
        prog[i] = enc_i(12'(random_below(64) * 4), 5'd0, 3'b010, random_reg(),
                        tinyrv1_pkg::OPC_LOAD);
      end else if (kind < 11) begin
        prog[i] = enc_s(12'(random_below(64) * 4), random_reg());
      end else begin
        pick = random_below(4);
        if (pick < 3) begin
          prog_mapped++;
        end
        prog[i] = enc_csrw(csr_of_pick(pick), random_reg());
      end
    end
  endtask

  // ==============================
  // ISA model
  // ==============================

  task automatic model_exec(input tinyrv1_pkg::inst_t w);
    tinyrv1_pkg::reg_addr_t rd;
    tinyrv1_pkg::word_t     a;
    tinyrv1_pkg::word_t     b;
    tinyrv1_pkg::word_t     res;
    tinyrv1_pkg::word_t     addr;
    tinyrv1_pkg::csr_out_t  exp_v;
    logic                   wr;
    rd  = w[11:7];
    a   = mreg[w[19:15]];
    b   = mreg[w[24:20]];
    res = '0;
    wr  = 1'b0;
    case (w[6:0])
      tinyrv1_pkg::OPC_OP: begin
        res = (w[31:25] == tinyrv1_pkg::F7_MUL) ? a * b : a + b;
        wr  = 1'b1;
      end
      tinyrv1_pkg::OPC_OP_IMM: begin
        res = a + {{20{w[31]}}, w[31:20]};
        wr  = 1'b1;
      end
      tinyrv1_pkg::OPC_LOAD: begin
        addr = a + {{20{w[31]}}, w[31:20]};
        res  = mmem[addr[7:2]];
        wr   = 1'b1;
      end
      tinyrv1_pkg::OPC_STORE: begin
        addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
        mmem[addr[7:2]] = b;
      end
      default: begin
        exp_v.data = a;
        exp_v.idx  = 2'd3;
        case (w[31:20])
          tinyrv1_pkg::CSR_OUT0: exp_v.idx = 2'd0;
          tinyrv1_pkg::CSR_OUT1: exp_v.idx = 2'd1;
          tinyrv1_pkg::CSR_OUT2: exp_v.idx = 2'd2;
          default:               exp_v.idx = 2'd3;
        endcase
        if (exp_v.idx != 2'd3) begin
          exp_q.push_back(exp_v);
        end
      end
    endcase
    // x0 stays zero
    if (wr && (rd != '0)) begin
      mreg[rd] = res;
    end
  endtask

  // ==============================
  // Checks
  // ==============================

  task automatic compare_csr_out(input tinyrv1_pkg::csr_out_t got,
                                 input tinyrv1_pkg::csr_out_t exp);
    if (got !== exp) begin
      mismatch_errors++;
      $display("MISMATCH t=%0t csr_out got idx=%0d data=%08h expected idx=%0d data=%08h",
               $time, got.idx, got.data, exp.idx, exp.data);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_errors++;
      $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    other_errors++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  // Registered outputs are sampled at the falling edge
  always @(negedge clk) begin : out_monitor
    tinyrv1_pkg::csr_out_t exp_v;
    if (arst_n && !inst_rdy) begin
      rdy_low_cycles++;
    end
    if (arst_n && csr_out_val) begin
      strobes++;
      if (exp_q.size() == 0) begin
        report_failure("CSR output strobe with no matching CSRW in the model");
      end else begin
        exp_v = exp_q.pop_front();
        compare_csr_out(csr_out, exp_v);
      end
    end
  end

  // ==============================
  // Stimulus
  // ==============================

  // Entered and left 1 ns after a rising edge
  task automatic send_inst(input tinyrv1_pkg::inst_t w, input logic allow_gap);
    int   gap;
    logic accepted;
    gap = 0;
    if (allow_gap && (random_below(2) != 0)) begin
      gap = 1 + random_below(3);
    end
    repeat (gap) begin
      inst_val = 1'b0;
      @(posedge clk);
      #1;
    end
    inst_val = 1'b1;
    inst     = w;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = inst_rdy;
      @(posedge clk);
      if (accepted) begin
        model_exec(w);
      end
      #1;
    end
    inst_val = 1'b0;
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_failure($sformatf("run did not finish within %0d cycles", WATCHDOG_CYCLES));
    $display("Error counts: %0d mismatches, %0d other failures", mismatch_errors,
             other_errors);
    $display("Checks failed");
    $finish;
  end

  initial begin : main
    int c;
    arst_n          = 1'b0;
    inst_val        = 1'b0;
    inst            = '0;
    rng_state       = 32'haa60_98cf;
    prog_mapped     = 0;
    strobes         = 0;
    rdy_low_cycles  = 0;
    mismatch_errors = 0;
    other_errors    = 0;
    for (int i = 0; i < 32; i++) begin
      mreg[i] = '0;
    end
    for (int i = 0; i < tinyrv1_pkg::DMEM_WORDS; i++) begin
      mmem[i] = '0;
    end
    build_program();

    repeat (RST_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    compare_bit("inst_rdy", inst_rdy, 1'b1);
    compare_bit("csr_out_val", csr_out_val, 1'b0);
    @(posedge clk);
    #1;

    for (int i = 0; i < N_INST; i++) begin
      send_inst(prog[i], !in_burst(i));
    end

    // Drain the pipeline and then watch for stray strobes
    c = 0;
    while ((exp_q.size() != 0) && (c < DRAIN_CYCLES)) begin
      @(posedge clk);
      c++;
    end
    repeat (8) @(posedge clk);

    if (exp_q.size() != 0) begin
      report_failure($sformatf("%0d expected CSR outputs never appeared", exp_q.size()));
    end
    if (strobes != prog_mapped) begin
      report_failure($sformatf("saw %0d CSR output strobes but program has %0d mapped CSRWs",
                               strobes, prog_mapped));
    end
    if (rdy_low_cycles == 0) begin
      report_failure("inst_rdy never went low although the load-use burst fills the queue");
    end

    $display("Error counts: %0d mismatches, %0d other failures", mismatch_errors,
             other_errors);
    if ((mismatch_errors == 0) && (other_errors == 0)) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
hw/tinyrv1_pkg.sv
hw/proc_inst_queue.sv
hw/proc_ctrl.sv
hw/proc_dpath.sv
hw/proc_top.sv
testbench/tb_clock_gen.sv
testbench/proc_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module proc_tb -o proc_tb_sim

out=$(./obj_dir/proc_tb_sim)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
